/* hdl/imuldiv_params.svh */
// sizing constants for the iterative multiply/divide unit
// included by the package, the RTL and the testbench

`ifndef IMULDIV_PARAMS_SVH
`define IMULDIV_PARAMS_SVH

// ------------------------------
// operand and step sizing
// ------------------------------

// operand width, results are twice this
`define IMULDIV_XLEN 32

// one iteration per operand bit
`define IMULDIV_STEPS 32

// wide enough to hold IMULDIV_STEPS - 1
`define IMULDIV_CNT_W 5

`endif

/* hdl/imuldiv_pkg.sv */
// shared types for the iterative multiply/divide unit
// imported by every RTL module and by the testbench

`include "imuldiv_params.svh"

package imuldiv_pkg;

  // ------------------------------
  // encodings
  // ------------------------------

  // request opcodes, signed and unsigned forms
  typedef enum logic [1:0] {
    OP_MUL  = 2'd0,
    OP_MULU = 2'd1,
    OP_DIV  = 2'd2,
    OP_DIVU = 2'd3
  } imuldiv_op_e;

  // controller states
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_CALC = 2'd1,
    ST_DONE = 2'd2
  } imuldiv_state_e;

  // ------------------------------
  // messages and control
  // ------------------------------

  // request message, 66 bits
  typedef struct packed {
    imuldiv_op_e              op;
    logic [`IMULDIV_XLEN-1:0] a;
    logic [`IMULDIV_XLEN-1:0] b;
  } imuldiv_req_t;

  // response message, remainder high and quotient low for a divide
  typedef struct packed {
    logic [2*`IMULDIV_XLEN-1:0] result;
  } imuldiv_resp_t;

  // steering from the controller to counter, sign unit and datapaths
  typedef struct packed {
    logic load;
    logic step;
    logic is_div;
  } imuldiv_ctrl_t;

endpackage

/* hdl/imuldiv_ctrl.sv */
// controller of the iterative multiply/divide unit
// runs both val/rdy handshakes and steers the datapaths

`timescale 1ns/1ps

module imuldiv_ctrl
  import imuldiv_pkg::*;
(
  input  logic          clk,
  input  logic          reset,
  input  imuldiv_op_e   req_op,
  input  logic          req_val,
  output logic          req_rdy,
  output logic          resp_val,
  input  logic          resp_rdy,
  input  logic          cnt_zero,
  output imuldiv_ctrl_t ctrl
);

  imuldiv_state_e state;
  imuldiv_state_e state_next;
  logic           is_div;
  logic           req_go;
  logic           resp_go;

  // ------------------------------
  // handshakes
  // ------------------------------

  // only take a request when nothing is in flight
  assign req_rdy  = (state == ST_IDLE);
  // result is held until the consumer takes it
  assign resp_val = (state == ST_DONE);

  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  // ------------------------------
  // state machine
  // ------------------------------

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        if (req_go) begin
          state_next = ST_CALC;
        end
      end
      ST_CALC: begin
        // counter reaches zero on the last step
        if (cnt_zero) begin
          state_next = ST_DONE;
        end
      end
      ST_DONE: begin
        // back-pressure just parks us here
        if (resp_go) begin
          state_next = ST_IDLE;
        end
      end
      default: begin
        state_next = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= ST_IDLE;
      is_div <= 1'b0;
    end else begin
      state <= state_next;
      // opcode class latched on the accepting edge
      if (req_go) begin
        is_div <= (req_op == OP_DIV) || (req_op == OP_DIVU);
      end
    end
  end

  // load coincides with acceptance, step covers every CALC edge
  always_comb begin
    ctrl.load   = req_go;
    ctrl.step   = (state == ST_CALC);
    ctrl.is_div = is_div;
  end

endmodule

/* hdl/imuldiv_counter.sv */
// iteration down-counter, loaded at acceptance and stepped in CALC
// its zero flag marks the final step for the controller

`timescale 1ns/1ps

`include "imuldiv_params.svh"

module imuldiv_counter
  import imuldiv_pkg::*;
(
  input  logic          clk,
  input  logic          reset,
  input  imuldiv_ctrl_t ctrl,
  output logic          cnt_zero
);

  localparam int CNT_W = `IMULDIV_CNT_W;

  // first step happens with this value, last one with zero
  localparam logic [CNT_W-1:0] CNT_INIT = CNT_W'(`IMULDIV_STEPS - 1);

  logic [CNT_W-1:0] cnt;

  always_ff @(posedge clk) begin
    if (reset) begin
      cnt <= '0;
    end else if (ctrl.load) begin
      cnt <= CNT_INIT;
    end else if (ctrl.step) begin
      cnt <= cnt - 1'b1;
    end
  end

  assign cnt_zero = (cnt == '0);

endmodule

/* hdl/imuldiv_sign_unit.sv */
// sign handling around the magnitude datapaths
// feeds operand magnitudes in and applies the final negations

`timescale 1ns/1ps

`include "imuldiv_params.svh"

module imuldiv_sign_unit
  import imuldiv_pkg::*;
(
  input  logic                     clk,
  input  logic                     reset,
  input  imuldiv_ctrl_t            ctrl,
  input  imuldiv_req_t             req,
  output logic [`IMULDIV_XLEN-1:0] mag_a,
  output logic [`IMULDIV_XLEN-1:0] mag_b,
  input  logic [2*`IMULDIV_XLEN-1:0] mul_prod,
  input  logic [`IMULDIV_XLEN-1:0] div_quot,
  input  logic [`IMULDIV_XLEN-1:0] div_rem,
  output imuldiv_resp_t            resp
);

  localparam int XLEN = `IMULDIV_XLEN;

  logic            req_signed;
  logic            neg_a;
  logic            neg_b;
  logic            is_signed;
  logic            neg_res;
  logic            neg_rem;
  logic [XLEN-1:0] quot_out;
  logic [XLEN-1:0] rem_out;

  // ------------------------------
  // operand magnitudes
  // ------------------------------

  // unsigned opcodes pass operands straight through
  assign req_signed = (req.op == OP_MUL) || (req.op == OP_DIV);
  // most negative value maps onto itself, which is right as unsigned
  assign mag_a = (req_signed && req.a[XLEN-1]) ? -req.a : req.a;
  assign mag_b = (req_signed && req.b[XLEN-1]) ? -req.b : req.b;

  // raw sign bits and opcode class, kept for the whole operation
  always_ff @(posedge clk) begin
    if (reset) begin
      neg_a     <= 1'b0;
      neg_b     <= 1'b0;
      is_signed <= 1'b0;
    end else if (ctrl.load) begin
      neg_a     <= req.a[XLEN-1];
      neg_b     <= req.b[XLEN-1];
      is_signed <= req_signed;
    end
  end

  // ------------------------------
  // result fix-up
  // ------------------------------

  // product and quotient flip on differing signs
  assign neg_res = is_signed && (neg_a ^ neg_b);
  // remainder follows the dividend
  assign neg_rem = is_signed && neg_a;

  assign quot_out = neg_res ? -div_quot : div_quot;
  assign rem_out  = neg_rem ? -div_rem : div_rem;

  always_comb begin
    if (ctrl.is_div) begin
      resp.result = {rem_out, quot_out};
    end else begin
      resp.result = neg_res ? -mul_prod : mul_prod;
    end
  end

endmodule

/* hdl/imuldiv_mul_dpath.sv */
// shift-and-add multiplier on operand magnitudes
// one multiplier bit is consumed per step, lsb first

`timescale 1ns/1ps

`include "imuldiv_params.svh"

module imuldiv_mul_dpath
  import imuldiv_pkg::*;
(
  input  logic                       clk,
  input  logic                       reset,
  input  imuldiv_ctrl_t              ctrl,
  input  logic [`IMULDIV_XLEN-1:0]   mag_a,
  input  logic [`IMULDIV_XLEN-1:0]   mag_b,
  output logic [2*`IMULDIV_XLEN-1:0] mul_prod
);

  localparam int XLEN = `IMULDIV_XLEN;

  // multiplicand walks left through the full product width
  logic [2*XLEN-1:0] mcand;
  // multiplier walks right, bit 0 decides each add
  logic [XLEN-1:0]   mplier;
  logic [2*XLEN-1:0] acc;

  // ------------------------------
  // iteration registers
  // ------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      mcand  <= '0;
      mplier <= '0;
      acc    <= '0;
    end else if (ctrl.load) begin
      mcand  <= {{XLEN{1'b0}}, mag_a};
      mplier <= mag_b;
      acc    <= '0;
    end else if (ctrl.step) begin
      // partial product added only for set multiplier bits
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // unsigned product, sign unit negates when needed
  assign mul_prod = acc;

endmodule

/* hdl/imuldiv_div_dpath.sv */
// restoring divider on operand magnitudes
// remainder and quotient share one register that shifts left each step

`timescale 1ns/1ps

`include "imuldiv_params.svh"

module imuldiv_div_dpath
  import imuldiv_pkg::*;
(
  input  logic                     clk,
  input  logic                     reset,
  input  imuldiv_ctrl_t            ctrl,
  input  logic [`IMULDIV_XLEN-1:0] mag_a,
  input  logic [`IMULDIV_XLEN-1:0] mag_b,
  output logic [`IMULDIV_XLEN-1:0] div_quot,
  output logic [`IMULDIV_XLEN-1:0] div_rem
);

  localparam int XLEN = `IMULDIV_XLEN;

  // upper half holds the partial remainder, lower half dividend/quotient bits
  logic [2*XLEN-1:0] rq;
  logic [XLEN-1:0]   divisor;
  // shifted partial remainder, one bit wider so the top bit is not lost
  logic [XLEN:0]     part;
  logic [XLEN+1:0]   diff;
  logic              fits;

  // ------------------------------
  // trial subtraction
  // ------------------------------

  assign part = rq[2*XLEN-1:XLEN-1];
  assign diff = {1'b0, part} - {2'b0, divisor};
  // no borrow means the divisor fits
  assign fits = ~diff[XLEN+1];

  // ------------------------------
  // iteration register
  // ------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      rq      <= '0;
      divisor <= '0;
    end else if (ctrl.load) begin
      rq      <= {{XLEN{1'b0}}, mag_a};
      divisor <= mag_b;
    end else if (ctrl.step) begin
      if (fits) begin
        // keep difference, new quotient bit shifts in as one
        rq <= {diff[XLEN-1:0], rq[XLEN-2:0], 1'b1};
      end else begin
        // restore, i.e. keep the plain shift
        rq <= {part[XLEN-1:0], rq[XLEN-2:0], 1'b0};
      end
    end
  end

  // zero divisor always fits, giving all ones and the dividend back
  assign div_quot = rq[XLEN-1:0];
  assign div_rem  = rq[2*XLEN-1:XLEN];

endmodule

/* hdl/imuldiv_iterative.sv */
// top level of the iterative multiply/divide unit
// val/rdy request in, 32 steps of work, val/rdy 64-bit response out

`timescale 1ns/1ps

`include "imuldiv_params.svh"

module imuldiv_iterative
  import imuldiv_pkg::*;
(
  input  logic          clk,
  input  logic          reset,
  input  imuldiv_req_t  req,
  input  logic          req_val,
  output logic          req_rdy,
  output imuldiv_resp_t resp,
  output logic          resp_val,
  input  logic          resp_rdy
);

  localparam int XLEN = `IMULDIV_XLEN;

  imuldiv_ctrl_t     ctrl;
  logic              cnt_zero;
  logic [XLEN-1:0]   mag_a;
  logic [XLEN-1:0]   mag_b;
  logic [2*XLEN-1:0] mul_prod;
  logic [XLEN-1:0]   div_quot;
  logic [XLEN-1:0]   div_rem;

  // ------------------------------
  // control
  // ------------------------------

  imuldiv_ctrl ctrl_i (
    .clk      (clk),
    .reset    (reset),
    .req_op   (req.op),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .cnt_zero (cnt_zero),
    .ctrl     (ctrl)
  );

  imuldiv_counter counter_i (
    .clk      (clk),
    .reset    (reset),
    .ctrl     (ctrl),
    .cnt_zero (cnt_zero)
  );

  // ------------------------------
  // datapath
  // ------------------------------

  // magnitudes in, signed result out
  imuldiv_sign_unit sign_unit_i (
    .clk      (clk),
    .reset    (reset),
    .ctrl     (ctrl),
    .req      (req),
    .mag_a    (mag_a),
    .mag_b    (mag_b),
    .mul_prod (mul_prod),
    .div_quot (div_quot),
    .div_rem  (div_rem),
    .resp     (resp)
  );

  // both datapaths run on every operation, the sign unit picks one
  imuldiv_mul_dpath mul_dpath_i (
    .clk      (clk),
    .reset    (reset),
    .ctrl     (ctrl),
    .mag_a    (mag_a),
    .mag_b    (mag_b),
    .mul_prod (mul_prod)
  );

  imuldiv_div_dpath div_dpath_i (
    .clk      (clk),
    .reset    (reset),
    .ctrl     (ctrl),
    .mag_a    (mag_a),
    .mag_b    (mag_b),
    .div_quot (div_quot),
    .div_rem  (div_rem)
  );

endmodule

/* tests/imuldiv_asserts.sv */
// handshake and protocol checks, bound onto the top level of the unit
// a violation is flagged through the failing assertion

`timescale 1ns/1ps

module imuldiv_asserts
  import imuldiv_pkg::*;
(
  input logic          clk,
  input logic          reset,
  input logic          req_rdy,
  input imuldiv_resp_t resp,
  input logic          resp_val,
  input logic          resp_rdy
);

  // ------------------------------
  // handshake rules
  // ------------------------------

  // the unit never takes a request while it presents a result
  req_resp_exclusive: assert property (
    @(posedge clk) disable iff (reset) !(req_rdy && resp_val)
  ) else $error("req_rdy and resp_val were high together");

  // a stalled response keeps val and payload until it is taken
  resp_held: assert property (
    @(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp))
  ) else $error("response changed or dropped under back-pressure");

  // sync reset clears the response side on the next edge
  resp_cleared: assert property (
    @(posedge clk) reset |=> !resp_val
  ) else $error("resp_val was high in the cycle after reset");

endmodule

bind imuldiv_iterative imuldiv_asserts asserts_i (
  .clk      (clk),
  .reset    (reset),
  .req_rdy  (req_rdy),
  .resp     (resp),
  .resp_val (resp_val),
  .resp_rdy (resp_rdy)
);

/* tests/imuldiv_tb.sv */
// self-checking testbench for the iterative multiply/divide unit
// directed and LFSR-random requests, checked against a reference model

`timescale 1ns/1ps

`include "imuldiv_params.svh"

module imuldiv_tb
  import imuldiv_pkg::*;
();

  localparam int XLEN      = `IMULDIV_XLEN;
  localparam int HALF_PER  = 20;
  localparam int DRIVE_DLY = 2;
  localparam int LATENCY   = `IMULDIV_STEPS;
  // about 250 operations at no more than 43 cycles each, plus margin
  localparam int TIMEOUT_CYCLES = 12000;

  logic          clk;
  logic          reset;
  imuldiv_req_t  req;
  logic          req_val;
  logic          req_rdy;
  imuldiv_resp_t resp;
  logic          resp_val;
  logic          resp_rdy;

  // scoreboard and monitor state
  imuldiv_resp_t expect_q[$];
  imuldiv_resp_t held_resp;
  logic [31:0]   lfsr_state;
  integer        cycle_cnt;
  integer        accept_cyc;
  logic          busy;
  logic          seen;
  logic          expect_rdy;

  imuldiv_iterative imuldiv_iterative_i (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp     (resp),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #HALF_PER clk = ~clk;
  end

  // ------------------------------
  // helpers
  // ------------------------------

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on the first failure");
  endtask

  task automatic check_resp(input imuldiv_resp_t got, input imuldiv_resp_t exp,
                            input string what);
    if (got !== exp) begin
      abort_run($sformatf("error: t=%0t %s got %h expected %h",
                          $time, what, got.result, exp.result));
    end
  endtask

  task automatic check_latency(input integer got, input integer exp);
    if (got != exp) begin
      abort_run($sformatf("error: t=%0t resp_val rose %0d cycles after accept, expected %0d",
                          $time, got, exp));
    end
  endtask

  // galois form, right shift, taps 32 31 29 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
  endfunction

  // one lfsr step per bit taken, msb first
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    repeat (n) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  // expected response from the opcode rules on operand magnitudes
  function automatic imuldiv_resp_t ref_result(input imuldiv_req_t r);
    logic              sgn;
    logic              neg_res;
    logic              neg_rem;
    logic [XLEN-1:0]   ma;
    logic [XLEN-1:0]   mb;
    logic [XLEN-1:0]   q;
    logic [XLEN-1:0]   rm;
    logic [2*XLEN-1:0] p;
    imuldiv_resp_t     res;
    sgn     = (r.op == OP_MUL) || (r.op == OP_DIV);
    ma      = (sgn && r.a[XLEN-1]) ? -r.a : r.a;
    mb      = (sgn && r.b[XLEN-1]) ? -r.b : r.b;
    neg_res = sgn && (r.a[XLEN-1] != r.b[XLEN-1]);
    neg_rem = sgn && r.a[XLEN-1];
    if ((r.op == OP_MUL) || (r.op == OP_MULU)) begin
      p = {{XLEN{1'b0}}, ma} * {{XLEN{1'b0}}, mb};
      res.result = neg_res ? -p : p;
    end else begin
      // a zero divisor lets every trial subtraction succeed
      if (mb == '0) begin
        q  = '1;
        rm = ma;
      end else begin
        q  = ma / mb;
        rm = ma % mb;
      end
      res.result = {(neg_rem ? -rm : rm), (neg_res ? -q : q)};
    end
    return res;
  endfunction

  // ------------------------------
  // stimulus tasks
  // ------------------------------

  // one full operation, consumer stalls for the given number of cycles
  task automatic run_op(input imuldiv_req_t r, input int stall);
    @(posedge clk);
    #DRIVE_DLY;
    req      = r;
    req_val  = 1'b1;
    resp_rdy = (stall == 0);
    @(negedge clk);
    while (!req_rdy) @(negedge clk);
    @(posedge clk);
    #DRIVE_DLY;
    req_val = 1'b0;
    // operands must already be latched, so scramble the bus
    req = imuldiv_req_t'(~r);
    @(negedge clk);
    while (!resp_val) @(negedge clk);
    if (stall > 0) begin
      repeat (stall) @(posedge clk);
      #DRIVE_DLY;
      resp_rdy = 1'b1;
    end
    while (!(resp_val && resp_rdy)) @(negedge clk);
    // transfer edge
    @(posedge clk);
    #DRIVE_DLY;
    resp_rdy = 1'b0;
  endtask

  task automatic run_pair(input imuldiv_op_e op_s, input imuldiv_op_e op_u,
                          input logic [31:0] a, input logic [31:0] b);
    imuldiv_req_t r;
    r.a  = a;
    r.b  = b;
    r.op = op_s;
    run_op(r, 0);
    r.op = op_u;
    run_op(r, 0);
  endtask

  // reset lands partway through the 32 steps
  task automatic reset_mid_calc(input imuldiv_req_t r);
    @(posedge clk);
    #DRIVE_DLY;
    req      = r;
    req_val  = 1'b1;
    resp_rdy = 1'b1;
    @(negedge clk);
    while (!req_rdy) @(negedge clk);
    @(posedge clk);
    #DRIVE_DLY;
    req_val = 1'b0;
    repeat (10) @(posedge clk);
    #DRIVE_DLY;
    reset = 1'b1;
    @(posedge clk);
    #DRIVE_DLY;
    reset = 1'b0;
    @(negedge clk);
    if (!req_rdy || resp_val) begin
      abort_run("reset during the calculation did not bring the unit back to idle");
    end
  endtask

  // ------------------------------
  // watchdog and monitor
  // ------------------------------

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      abort_run("timeout: the tests did not finish within the cycle limit");
    end
  end

  // mid-cycle sampling, all signals settled here
  always @(negedge clk) begin
    imuldiv_resp_t exp;
    if (reset) begin
      // an operation cut off by reset yields no response
      expect_q.delete();
      busy       = 1'b0;
      seen       = 1'b0;
      expect_rdy = 1'b0;
    end else begin
      if (expect_rdy && !req_rdy) begin
        abort_run("req_rdy did not rise one cycle after the response transfer");
      end
      expect_rdy = 1'b0;
      if (busy && req_rdy) begin
        abort_run("req_rdy rose while an operation was in flight");
      end
      if (req_val && req_rdy) begin
        expect_q.push_back(ref_result(req));
        // count the accepting edge itself
        accept_cyc = cycle_cnt + 1;
        busy       = 1'b1;
      end
      if (resp_val && !busy) begin
        abort_run("resp_val rose with no request in flight");
      end else if (resp_val) begin
        if (!seen) begin
          check_latency(cycle_cnt - accept_cyc, LATENCY);
          held_resp = resp;
          seen      = 1'b1;
        end else begin
          check_resp(resp, held_resp, "stalled response");
        end
        if (resp_rdy) begin
          exp = expect_q.pop_front();
          check_resp(resp, exp, "response");
          busy       = 1'b0;
          seen       = 1'b0;
          expect_rdy = 1'b1;
        end
      end
    end
  end

  // ------------------------------
  // test sequence
  // ------------------------------

  initial begin
    imuldiv_req_t r;
    logic [31:0]  bits;
    int           stall;
    reset      = 1'b1;
    req        = '0;
    req_val    = 1'b0;
    resp_rdy   = 1'b0;
    lfsr_state = 32'd92;
    cycle_cnt  = 0;
    accept_cyc = 0;
    busy       = 1'b0;
    seen       = 1'b0;
    expect_rdy = 1'b0;
    held_resp  = '0;
    repeat (5) @(posedge clk);
    #DRIVE_DLY;
    reset = 1'b0;

    // directed multiplies, signed and unsigned on the same operands
    run_pair(OP_MUL, OP_MULU, 32'h0000_0000, 32'h0000_0000);
    run_pair(OP_MUL, OP_MULU, 32'h0000_0000, 32'h0000_0005);
    run_pair(OP_MUL, OP_MULU, 32'h0000_0001, 32'hDEAD_BEEF);
    run_pair(OP_MUL, OP_MULU, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
    run_pair(OP_MUL, OP_MULU, 32'h8000_0000, 32'h8000_0000);
    run_pair(OP_MUL, OP_MULU, 32'h8000_0000, 32'hFFFF_FFFF);
    run_pair(OP_MUL, OP_MULU, 32'h7FFF_FFFF, 32'h7FFF_FFFF);
    run_pair(OP_MUL, OP_MULU, 32'hFFFF_FFFD, 32'h0000_0007);
    run_pair(OP_MUL, OP_MULU, 32'h0000_0003, 32'hFFFF_FFF9);
    run_pair(OP_MUL, OP_MULU, 32'hFFFF_FFFD, 32'hFFFF_FFF9);
    run_pair(OP_MUL, OP_MULU, 32'h1234_5678, 32'h9ABC_DEF0);

    // directed divides, every sign mix, zero divisor, overflow case
    run_pair(OP_DIV, OP_DIVU, 32'd100, 32'd10);
    run_pair(OP_DIV, OP_DIVU, 32'd100, 32'd7);
    run_pair(OP_DIV, OP_DIVU, 32'hFFFF_FF9C, 32'd7);
    run_pair(OP_DIV, OP_DIVU, 32'd100, 32'hFFFF_FFF9);
    run_pair(OP_DIV, OP_DIVU, 32'hFFFF_FF9C, 32'hFFFF_FFF9);
    run_pair(OP_DIV, OP_DIVU, 32'h0000_1234, 32'h0000_0000);
    run_pair(OP_DIV, OP_DIVU, 32'hFFFF_FFFB, 32'h0000_0000);
    run_pair(OP_DIV, OP_DIVU, 32'h0000_0000, 32'h0000_0000);
    run_pair(OP_DIV, OP_DIVU, 32'h8000_0000, 32'hFFFF_FFFF);
    run_pair(OP_DIV, OP_DIVU, 32'h8000_0000, 32'h0000_0001);
    run_pair(OP_DIV, OP_DIVU, 32'h7FFF_FFFF, 32'h0000_0002);
    run_pair(OP_DIV, OP_DIVU, 32'h0000_0001, 32'hFFFF_FFFF);
    run_pair(OP_DIV, OP_DIVU, 32'hDEAD_BEEF, 32'h0000_1234);

    // random requests with 0 to 8 cycles of back-pressure
    for (int i = 0; i < 200; i++) begin
      take_bits(2, bits);
      r.op = imuldiv_op_e'(bits[1:0]);
      take_bits(32, bits);
      r.a = bits;
      take_bits(32, bits);
      r.b = bits;
      // a quarter of the divisors are small, for wide quotients
      take_bits(2, bits);
      if (bits[1:0] == 2'b00) begin
        r.b = {{24{r.b[7]}}, r.b[7:0]};
      end
      take_bits(4, bits);
      stall = bits % 9;
      run_op(r, stall);
    end

    // reset while busy, then a normal operation afterwards
    r.op = OP_MUL;
    r.a  = 32'hCAFE_0001;
    r.b  = 32'h0000_BEEF;
    reset_mid_calc(r);
    r.op = OP_DIV;
    r.a  = 32'hF000_0007;
    r.b  = 32'h0000_0013;
    run_op(r, 3);

    repeat (2) @(posedge clk);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

/* flist.f */
+incdir+hdl
hdl/imuldiv_pkg.sv
hdl/imuldiv_ctrl.sv
hdl/imuldiv_counter.sv
hdl/imuldiv_sign_unit.sv
hdl/imuldiv_mul_dpath.sv
hdl/imuldiv_div_dpath.sv
hdl/imuldiv_iterative.sv
tests/imuldiv_asserts.sv
tests/imuldiv_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the multiply/divide unit and its testbench with Verilator, then run it
# a nonzero exit status means the build failed or the testbench stopped on a failure

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module imuldiv_tb -f flist.f -o Vimuldiv_tb
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/Vimuldiv_tb
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

echo "simulation completed"
exit 0
